/* files.f */
+incdir+sim
src/ex_pkg.sv
src/ex_alu.sv
src/ex_mult.sv
src/ex_writeback.sv
src/ex_stage.sv
sim/tb_ex_stage.sv

/* sim/ex_tests.svh */
// Reference models and directed tests for ALU, multiplier, forwarding, load/store port and stalls
`ifndef EX_TESTS_SVH
`define EX_TESTS_SVH

//////////////////////////////////////////////////
// Reference models
//////////////////////////////////////////////////

// Branch condition or less-than bit for SLT and SLTU
function automatic logic alu_ref_cmp(input alu_op_e op, input word_t a, input word_t b);
  case (op)
    ALU_SLT, ALU_LT:   return $signed(a) < $signed(b);
    ALU_SLTU, ALU_LTU: return a < b;
    ALU_EQ:            return a == b;
    ALU_NE:            return a != b;
    ALU_GE:            return $signed(a) >= $signed(b);
    ALU_GEU:           return a >= b;
    default:           return 1'b0;
  endcase
endfunction

function automatic word_t alu_ref_result(input alu_op_e op, input word_t a, input word_t b);
  logic signed [31:0] a_signed;
  a_signed = a;
  case (op)
    ALU_ADD: return a + b;
    ALU_SUB: return a - b;
    ALU_AND: return a & b;
    ALU_OR:  return a | b;
    ALU_XOR: return a ^ b;
    // Shift amount is the low five bits of b
    ALU_SLL: return a << b[4:0];
    ALU_SRL: return a >> b[4:0];
    ALU_SRA: return a_signed >>> b[4:0];
    default: return {31'b0, alu_ref_cmp(op, a, b)};
  endcase
endfunction

// Full 64 bit product with operands extended by signedness
function automatic logic [63:0] mult_ref_product(input mult_op_e op, input word_t a,
                                                 input word_t b);
  logic [63:0] ext_a;
  logic [63:0] ext_b;
  ext_a = {32'b0, a};
  ext_b = {32'b0, b};
  if (op == MULT_MULH || op == MULT_MULHSU) begin
    ext_a = {{32{a[31]}}, a};
  end
  if (op == MULT_MULH) begin
    ext_b = {{32{b[31]}}, b};
  end
  return ext_a * ext_b;
endfunction

// Upper word of the full 64 bit product
function automatic word_t mult_ref_high(input mult_op_e op, input word_t a, input word_t b);
  logic [63:0] product;
  product = mult_ref_product(op, a, b);
  return product[63:32];
endfunction

// Lower word of the full 64 bit product
function automatic word_t mult_ref_low(input word_t a, input word_t b);
  logic [63:0] product;
  product = mult_ref_product(MULT_MUL, a, b);
  return product[31:0];
endfunction

//////////////////////////////////////////////////
// Multiplier helper
//////////////////////////////////////////////////

// High op with WB optionally stalled in DONE for hold cycles
task automatic run_high_mult(input mult_op_e op, input word_t a, input word_t b, input int hold);
  word_t expected;
  int    busy;
  expected = mult_ref_high(op, a, b);
  step_cycle();
  mult_req.operator  = op;
  mult_req.operand_a = a;
  mult_req.operand_b = b;
  mult_en            = 1'b1;
  regfile_alu_we     = 1'b1;
  if (hold > 0) begin
    wb_ready = 1'b0;
  end
  #SAMPLE_DELAY;
  busy = 0;
  while (mult_multicycle && busy < MULT_LIMIT) begin
    check_bit("ex_ready_o while multiplier busy", ex_ready, 1'b0);
    busy++;
    step_cycle();
    #SAMPLE_DELAY;
  end
  if (busy == MULT_LIMIT) begin
    report_failure($sformatf("Multiplier never finished %s", op.name()));
  end else if (busy != 2) begin
    report_failure($sformatf("%s held mult_multicycle_o high for %0d cycles instead of 2",
                             op.name(), busy));
  end
  // DONE holds the result while the stage is stalled
  for (int i = 0; i < hold; i++) begin
    check_bit("ex_ready_o in DONE with wb_ready_i low", ex_ready, 1'b0);
    check_word($sformatf("regfile_alu_fw_o.wdata %s held", op.name()), fw_port.wdata, expected);
    step_cycle();
    #SAMPLE_DELAY;
  end
  if (hold > 0) begin
    step_cycle();
    wb_ready = 1'b1;
    #SAMPLE_DELAY;
    check_bit("mult_multicycle_o in DONE", mult_multicycle, 1'b0);
  end
  check_bit("ex_ready_o in DONE", ex_ready, 1'b1);
  check_word($sformatf("regfile_alu_fw_o.wdata %s", op.name()), fw_port.wdata, expected);
  step_cycle();
  mult_en        = 1'b0;
  regfile_alu_we = 1'b0;
endtask

//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////

task automatic alu_ops_test();
  alu_op_e op;
  word_t   a;
  word_t   b;
  word_t   exp_result;
  logic    exp_cmp;
  for (int i = 0; i < 16; i++) begin
    op = alu_op_e'(i);
    for (int v = 0; v < ALU_VECTORS; v++) begin
      // Corner operands first and random ones after
      case (v)
        0: begin
          a = '0;
          b = '0;
        end
        1: begin
          a = 32'hFFFF_FFFF;
          b = 32'h0000_0001;
        end
        2: begin
          a = 32'h8000_0000;
          b = 32'h7FFF_FFFF;
        end
        3: begin
          a = $random(seed);
          b = a;
        end
        4: begin
          a = 32'h8765_4321;
          b = 32'h0000_001F;
        end
        default: begin
          a = $random(seed);
          b = $random(seed);
        end
      endcase
      exp_result = alu_ref_result(op, a, b);
      exp_cmp    = alu_ref_cmp(op, a, b);
      step_cycle();
      alu_req.operator  = op;
      alu_req.operand_a = a;
      alu_req.operand_b = b;
      alu_en            = 1'b1;
      regfile_alu_we    = 1'b1;
      regfile_alu_waddr = reg_addr_t'($random(seed));
      #SAMPLE_DELAY;
      check_word($sformatf("regfile_alu_fw_o.wdata %s", op.name()), fw_port.wdata, exp_result);
      // Only compare ops define the branch condition
      if (op >= ALU_SLT) begin
        check_bit($sformatf("branch_decision_o %s", op.name()), branch_decision, exp_cmp);
      end
    end
  end
  step_cycle();
  alu_en         = 1'b0;
  regfile_alu_we = 1'b0;
  end_test("alu_ops");
endtask

task automatic mult_test();
  word_t a;
  word_t b;
  // Low product in the enable cycle without stall
  for (int v = 0; v < MUL_VECTORS; v++) begin
    a = $random(seed);
    b = $random(seed);
    step_cycle();
    mult_req.operator  = MULT_MUL;
    mult_req.operand_a = a;
    mult_req.operand_b = b;
    mult_en            = 1'b1;
    #SAMPLE_DELAY;
    check_word("regfile_alu_fw_o.wdata MULT_MUL", fw_port.wdata, mult_ref_low(a, b));
    check_bit("ex_ready_o for MULT_MUL", ex_ready, 1'b1);
    check_bit("mult_multicycle_o for MULT_MUL", mult_multicycle, 1'b0);
  end
  step_cycle();
  mult_en = 1'b0;
  for (int i = 1; i < 4; i++) begin
    for (int v = 0; v < HIGH_VECTORS; v++) begin
      case (v)
        0: begin
          a = 32'h8000_0000;
          b = 32'h8000_0000;
        end
        1: begin
          a = 32'hFFFF_FFFF;
          b = 32'hFFFF_FFFF;
        end
        2: begin
          a = 32'h7FFF_FFFF;
          b = 32'h8000_0001;
        end
        default: begin
          a = $random(seed);
          b = $random(seed);
        end
      endcase
      run_high_mult(mult_op_e'(i), a, b, 0);
    end
  end
  end_test("multiplier");
endtask

task automatic fw_priority_test();
  word_t fw_exp;
  word_t rnd;
  for (int c = 0; c < 8; c++) begin
    step_cycle();
    alu_req.operator   = ALU_ADD;
    alu_req.operand_a  = $random(seed);
    alu_req.operand_b  = $random(seed);
    mult_req.operator  = MULT_MUL;
    mult_req.operand_a = $random(seed);
    mult_req.operand_b = $random(seed);
    csr_rdata          = $random(seed);
    alu_en             = c[0];
    mult_en            = c[1];
    csr_access         = c[2];
    rnd                = $random(seed);
    regfile_alu_we     = rnd[0];
    regfile_alu_waddr  = reg_addr_t'($random(seed));
    // CSR over multiplier over ALU and zero when idle
    if (csr_access) begin
      fw_exp = csr_rdata;
    end else if (mult_en) begin
      fw_exp = mult_ref_low(mult_req.operand_a, mult_req.operand_b);
    end else if (alu_en) begin
      fw_exp = alu_ref_result(ALU_ADD, alu_req.operand_a, alu_req.operand_b);
    end else begin
      fw_exp = '0;
    end
    #SAMPLE_DELAY;
    check_word($sformatf("regfile_alu_fw_o.wdata enables %0d", c), fw_port.wdata, fw_exp);
    check_bit("regfile_alu_fw_o.we", fw_port.we, regfile_alu_we);
    check_addr("regfile_alu_fw_o.waddr", fw_port.waddr, regfile_alu_waddr);
  end
  step_cycle();
  alu_en         = 1'b0;
  mult_en        = 1'b0;
  csr_access     = 1'b0;
  regfile_alu_we = 1'b0;
  end_test("fw_priority");
endtask

task automatic lsu_port_test();
  reg_addr_t addr_first;
  reg_addr_t addr_held;
  reg_addr_t addr_other;
  word_t     data;
  addr_first = 6'h0B;
  addr_held  = 6'h2A;
  addr_other = 6'h15;
  // Accepted load
  step_cycle();
  lsu_en        = 1'b1;
  regfile_we    = 1'b1;
  regfile_waddr = addr_first;
  lsu_rdata     = $random(seed);
  #SAMPLE_DELAY;
  check_bit("ex_valid_o for load", ex_valid, 1'b1);
  // Faulting access follows directly
  step_cycle();
  data          = $random(seed);
  lsu_rdata     = data;
  lsu_err       = 1'b1;
  regfile_waddr = addr_other;
  #SAMPLE_DELAY;
  check_bit("regfile_wb_o.we after load", wb_port.we, 1'b1);
  check_addr("regfile_wb_o.waddr after load", wb_port.waddr, addr_first);
  check_word("regfile_wb_o.wdata after load", wb_port.wdata, data);
  step_cycle();
  lsu_err       = 1'b0;
  regfile_waddr = addr_held;
  #SAMPLE_DELAY;
  check_bit("regfile_wb_o.we after lsu_err_i", wb_port.we, 1'b0);
  // Strobe and address hold while WB stalls
  step_cycle();
  wb_ready      = 1'b0;
  regfile_waddr = addr_other;
  #SAMPLE_DELAY;
  check_bit("ex_valid_o with wb_ready_i low", ex_valid, 1'b0);
  check_bit("regfile_wb_o.we in stall", wb_port.we, 1'b1);
  check_addr("regfile_wb_o.waddr in stall", wb_port.waddr, addr_held);
  step_cycle();
  #SAMPLE_DELAY;
  check_bit("regfile_wb_o.we held", wb_port.we, 1'b1);
  check_addr("regfile_wb_o.waddr held", wb_port.waddr, addr_held);
  // Idle cycle with WB ready flushes the strobe
  step_cycle();
  wb_ready   = 1'b1;
  lsu_en     = 1'b0;
  regfile_we = 1'b0;
  #SAMPLE_DELAY;
  check_bit("regfile_wb_o.we before flush", wb_port.we, 1'b1);
  step_cycle();
  #SAMPLE_DELAY;
  check_bit("regfile_wb_o.we after idle cycle", wb_port.we, 1'b0);
  end_test("lsu_port");
endtask

task automatic backpressure_test();
  word_t target;
  step_cycle();
  alu_req.operator = ALU_ADD;
  alu_en           = 1'b1;
  wb_ready         = 1'b0;
  #SAMPLE_DELAY;
  check_bit("ex_ready_o with wb_ready_i low", ex_ready, 1'b0);
  check_bit("ex_valid_o with wb_ready_i low", ex_valid, 1'b0);
  step_cycle();
  wb_ready     = 1'b1;
  lsu_ready_ex = 1'b0;
  #SAMPLE_DELAY;
  check_bit("ex_ready_o with lsu_ready_ex_i low", ex_ready, 1'b0);
  check_bit("ex_valid_o with lsu_ready_ex_i low", ex_valid, 1'b0);
  step_cycle();
  lsu_ready_ex = 1'b1;
  #SAMPLE_DELAY;
  check_bit("ex_ready_o with all ready", ex_ready, 1'b1);
  check_bit("ex_valid_o with all ready", ex_valid, 1'b1);
  // Branch in EX overrides the stall
  step_cycle();
  wb_ready     = 1'b0;
  branch_in_ex = 1'b1;
  #SAMPLE_DELAY;
  check_bit("ex_ready_o with branch_in_ex_i", ex_ready, 1'b1);
  check_bit("ex_valid_o with branch_in_ex_i", ex_valid, 1'b0);
  step_cycle();
  wb_ready      = 1'b1;
  branch_in_ex  = 1'b0;
  alu_en        = 1'b0;
  target        = $random(seed);
  alu_operand_c = target;
  #SAMPLE_DELAY;
  check_word("jump_target_o", jump_target, target);
  run_high_mult(MULT_MULH, $random(seed), $random(seed), 3);
  end_test("backpressure");
endtask

`endif

/* sim/tb_ex_stage.sv */
// Testbench top with clock, reset, DUT, watchdog, compare tasks and test sequence
`timescale 1ns/100ps

module tb_ex_stage;
  import ex_pkg::*;

  //////////////////////////////////////////////////
  // Timing and test lengths
  //////////////////////////////////////////////////

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 10;
  localparam int SAMPLE_DELAY = 40;
  localparam int RESET_CYCLES = 5;

  // Vectors per test
  localparam int ALU_VECTORS  = 12;
  localparam int MUL_VECTORS  = 8;
  localparam int HIGH_VECTORS = 5;
  localparam int MULT_LIMIT   = 8;

  // Cycle budget for the watchdog
  localparam int MULT_SLOT       = 5;
  localparam int PRIO_CYCLES     = 9;
  localparam int LSU_CYCLES      = 12;
  localparam int BP_CYCLES       = 16;
  localparam int MARGIN_CYCLES   = 40;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 2 + 16 * ALU_VECTORS + 1 + MUL_VECTORS + 1
                                 + 3 * HIGH_VECTORS * MULT_SLOT + PRIO_CYCLES + LSU_CYCLES
                                 + BP_CYCLES + MARGIN_CYCLES;

  //////////////////////////////////////////////////
  // DUT signals
  //////////////////////////////////////////////////

  logic      clk = 1'b0;
  logic      rst_n;
  alu_req_t  alu_req;
  logic      alu_en;
  mult_req_t mult_req;
  logic      mult_en;
  word_t     alu_operand_c;
  logic      csr_access;
  word_t     csr_rdata;
  logic      lsu_en;
  word_t     lsu_rdata;
  logic      lsu_ready_ex;
  logic      lsu_err;
  logic      wb_ready;
  logic      branch_in_ex;
  logic      regfile_alu_we;
  reg_addr_t regfile_alu_waddr;
  logic      regfile_we;
  reg_addr_t regfile_waddr;
  rf_port_t  fw_port;
  rf_port_t  wb_port;
  logic      mult_multicycle;
  logic      branch_decision;
  word_t     jump_target;
  logic      ex_ready;
  logic      ex_valid;

  // Bookkeeping
  int     errors      = 0;
  int     checks      = 0;
  int     tests_run   = 0;
  int     last_errors = 0;
  integer seed        = 7350;

  always #(CLK_PERIOD / 2) clk = ~clk;

  ex_stage i_ex_stage (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_req_i           (alu_req),
    .alu_en_i            (alu_en),
    .mult_req_i          (mult_req),
    .mult_en_i           (mult_en),
    .alu_operand_c_i     (alu_operand_c),
    .csr_access_i        (csr_access),
    .csr_rdata_i         (csr_rdata),
    .lsu_en_i            (lsu_en),
    .lsu_rdata_i         (lsu_rdata),
    .lsu_ready_ex_i      (lsu_ready_ex),
    .lsu_err_i           (lsu_err),
    .wb_ready_i          (wb_ready),
    .branch_in_ex_i      (branch_in_ex),
    .regfile_alu_we_i    (regfile_alu_we),
    .regfile_alu_waddr_i (regfile_alu_waddr),
    .regfile_we_i        (regfile_we),
    .regfile_waddr_i     (regfile_waddr),
    .regfile_alu_fw_o    (fw_port),
    .regfile_wb_o        (wb_port),
    .mult_multicycle_o   (mult_multicycle),
    .branch_decision_o   (branch_decision),
    .jump_target_o       (jump_target),
    .ex_ready_o          (ex_ready),
    .ex_valid_o          (ex_valid)
  );

  //////////////////////////////////////////////////
  // Compare and report helpers
  //////////////////////////////////////////////////

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%s", what);
  endtask

  // One line per finished test
  task automatic end_test(input string name);
    $display("Test %-14s finished, %0d errors", name, errors - last_errors);
    last_errors = errors;
    tests_run++;
  endtask

  // Inputs change a little after the rising edge
  task automatic step_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic init_inputs();
    rst_n             = 1'b0;
    alu_req           = '0;
    alu_en            = 1'b0;
    mult_req          = '0;
    mult_en           = 1'b0;
    alu_operand_c     = '0;
    csr_access        = 1'b0;
    csr_rdata         = '0;
    lsu_en            = 1'b0;
    lsu_rdata         = '0;
    lsu_ready_ex      = 1'b1;
    lsu_err           = 1'b0;
    wb_ready          = 1'b1;
    branch_in_ex      = 1'b0;
    regfile_alu_we    = 1'b0;
    regfile_alu_waddr = '0;
    regfile_we        = 1'b0;
    regfile_waddr     = '0;
  endtask

  // Reset values are checked while reset is still low
  task automatic reset_dut();
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #SAMPLE_DELAY;
    check_bit("regfile_wb_o.we in reset", wb_port.we, 1'b0);
    check_addr("regfile_wb_o.waddr in reset", wb_port.waddr, '0);
    check_bit("mult_multicycle_o in reset", mult_multicycle, 1'b0);
    step_cycle();
    rst_n = 1'b1;
    end_test("reset");
  endtask

  `include "ex_tests.svh"

  //////////////////////////////////////////////////
  // Watchdog and test sequence
  //////////////////////////////////////////////////

  initial begin
    #(CLK_PERIOD * WATCHDOG_CYCLES);
    $display("Timeout after %0d cycles, the test sequence did not complete", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    init_inputs();
    reset_dut();
    alu_ops_test();
    mult_test();
    fw_priority_test();
    lsu_port_test();
    backpressure_test();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* src/ex_alu.sv */
// Integer ALU with adder, logic unit, barrel shifter and branch comparator
`timescale 1ns/100ps

module ex_alu (
  input  ex_pkg::alu_req_t req_i,
  output ex_pkg::word_t    result_o,
  output logic             cmp_o
);
  import ex_pkg::*;

  word_t       op_a;
  word_t       op_b;
  word_t       sum;
  logic        cmp_signed;
  logic [32:0] diff;
  logic        is_equal;
  logic        is_less;
  logic        shift_left;
  logic        shift_arith;
  word_t       shift_in;
  logic [32:0] shift_ext;
  word_t       shift_out;
  word_t       shift_res;

  assign op_a = req_i.operand_a;
  assign op_b = req_i.operand_b;

  //////////////////////////////////////////////////
  // Adder and comparator
  //////////////////////////////////////////////////

  // Signed compares extend with the sign bit
  always_comb begin
    case (req_i.operator)
      ALU_SLT, ALU_LT, ALU_GE: cmp_signed = 1'b1;
      default:                 cmp_signed = 1'b0;
    endcase
  end

  assign sum = op_a + op_b;

  // 33 bit difference, bit 32 is the sign of a - b in either mode
  assign diff     = {cmp_signed & op_a[31], op_a} - {cmp_signed & op_b[31], op_b};
  assign is_equal = (diff[31:0] == '0);
  assign is_less  = diff[32];

  //////////////////////////////////////////////////
  // Barrel shifter
  //////////////////////////////////////////////////

  // Left shifts reuse the right shifter on bit reversed data
  assign shift_left  = (req_i.operator == ALU_SLL);
  assign shift_arith = (req_i.operator == ALU_SRA);

  always_comb begin
    for (int i = 0; i < 32; i++) begin
      shift_in[i] = shift_left ? op_a[31-i] : op_a[i];
    end
  end

  // Extra top bit carries the fill value
  assign shift_ext = {shift_arith & op_a[31], shift_in};
  assign shift_out = word_t'($signed(shift_ext) >>> op_b[4:0]);

  // Undo the reversal for left shifts
  always_comb begin
    for (int i = 0; i < 32; i++) begin
      shift_res[i] = shift_left ? shift_out[31-i] : shift_out[i];
    end
  end

  //////////////////////////////////////////////////
  // Condition and result select
  //////////////////////////////////////////////////

  always_comb begin
    case (req_i.operator)
      ALU_EQ:                             cmp_o = is_equal;
      ALU_NE:                             cmp_o = ~is_equal;
      ALU_SLT, ALU_SLTU, ALU_LT, ALU_LTU: cmp_o = is_less;
      ALU_GE, ALU_GEU:                    cmp_o = ~is_less;
      default:                            cmp_o = 1'b0;
    endcase
  end

  always_comb begin
    case (req_i.operator)
      ALU_ADD:                   result_o = sum;
      ALU_SUB:                   result_o = diff[31:0];
      ALU_AND:                   result_o = op_a & op_b;
      ALU_OR:                    result_o = op_a | op_b;
      ALU_XOR:                   result_o = op_a ^ op_b;
      ALU_SLL, ALU_SRL, ALU_SRA: result_o = shift_res;
      // Compare ops return the condition zero extended
      default:                   result_o = {31'b0, cmp_o};
    endcase
  end

endmodule

/* src/ex_mult.sv */
// Multiplier with single cycle low product and two step high product sequencer
`timescale 1ns/100ps

module ex_mult (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              en_i,
  input  ex_pkg::mult_req_t req_i,
  input  logic              ex_ready_i,
  output ex_pkg::word_t     result_o,
  output logic              ready_o,
  output logic              multicycle_o
);
  import ex_pkg::*;

  mult_state_e        state_q;
  mult_state_e        state_cur;
  mult_state_e        state_d;
  logic               high_op;
  logic               sign_a;
  logic               sign_b;
  logic signed [32:0] op_a_ext;
  logic signed [32:0] op_b_ext;
  logic signed [16:0] pp_b;
  logic signed [63:0] partial;
  logic        [63:0] acc_d;
  logic        [63:0] acc_q;
  word_t              low_product;

  //////////////////////////////////////////////////
  // Low product
  //////////////////////////////////////////////////

  // Low word is the same for signed and unsigned operands
  assign low_product = req_i.operand_a * req_i.operand_b;

  //////////////////////////////////////////////////
  // High product datapath
  //////////////////////////////////////////////////

  assign high_op = (req_i.operator != MULT_MUL);

  // MULH signs both, MULHSU only a, MULHU neither
  assign sign_a = (req_i.operator == MULT_MULH) || (req_i.operator == MULT_MULHSU);
  assign sign_b = (req_i.operator == MULT_MULH);

  assign op_a_ext = {sign_a & req_i.operand_a[31], req_i.operand_a};
  assign op_b_ext = {sign_b & req_i.operand_b[31], req_i.operand_b};

  // Low half of b is always positive
  // High half keeps the extension bit and so carries the sign
  assign pp_b = (state_cur == STEP_HI) ? op_b_ext[32:16] : {1'b0, op_b_ext[15:0]};

  // One shared 33x17 signed multiplier, sign extended to 64 bits
  assign partial = op_a_ext * pp_b;

  always_comb begin
    case (state_cur)
      // Fresh accumulation of the low half partial product
      STEP_LO: acc_d = partial;
      // High half partial product weighs 2^16
      STEP_HI: acc_d = acc_q + (partial <<< 16);
      default: acc_d = acc_q;
    endcase
  end

  always_ff @(posedge clk) begin
    acc_q <= acc_d;
  end

  //////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////

  // A high op arriving in IDLE does its first step in that same cycle
  always_comb begin
    state_cur = state_q;
    if ((state_q == IDLE) && en_i && high_op) begin
      state_cur = STEP_LO;
    end
  end

  always_comb begin
    state_d = state_cur;
    case (state_cur)
      STEP_LO: state_d = STEP_HI;
      STEP_HI: state_d = DONE;
      // Result stays until the stage moves on
      DONE: begin
        if (ex_ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Busy during both steps
  assign multicycle_o = (state_cur == STEP_LO) || (state_cur == STEP_HI);
  assign ready_o      = ~multicycle_o;

  // Upper word of the accumulated product once done
  assign result_o = (state_cur == DONE) ? acc_q[63:32] : low_product;

endmodule

/* src/ex_pkg.sv */
// Execute stage package with data vectors, ALU and multiplier enums and port structs
package ex_pkg;

  //////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////

  // Operands, results, CSR and load data
  typedef logic [31:0] word_t;

  // Register file address, upper bit selects the FP bank
  typedef logic [5:0]  reg_addr_t;

  //////////////////////////////////////////////////
  // Operation encodings
  //////////////////////////////////////////////////

  // Arithmetic, logic and shift operations first
  // Compare operations follow and return the condition bit
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    // Branch comparisons
    ALU_EQ   = 4'hA,
    ALU_NE   = 4'hB,
    ALU_LT   = 4'hC,
    ALU_GE   = 4'hD,
    ALU_LTU  = 4'hE,
    ALU_GEU  = 4'hF
  } alu_op_e;

  // Low product and the three high product flavours
  typedef enum logic [1:0] {
    MULT_MUL    = 2'b00,
    MULT_MULH   = 2'b01,
    MULT_MULHSU = 2'b10,
    MULT_MULHU  = 2'b11
  } mult_op_e;

  // High product sequencer
  typedef enum logic [1:0] {
    IDLE    = 2'b00,
    STEP_LO = 2'b01,
    STEP_HI = 2'b10,
    DONE    = 2'b11
  } mult_state_e;

  //////////////////////////////////////////////////
  // Request and port structs
  //////////////////////////////////////////////////

  typedef struct packed {
    alu_op_e operator;
    word_t   operand_a;
    word_t   operand_b;
  } alu_req_t;

  typedef struct packed {
    mult_op_e operator;
    word_t    operand_a;
    word_t    operand_b;
  } mult_req_t;

  // One register file write port
  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;
  } rf_port_t;

endpackage

/* src/ex_stage.sv */
// Execute stage top with ALU, multiplier, write-back logic and branch outputs
`timescale 1ns/100ps

module ex_stage (
  input  logic              clk,
  input  logic              rst_n,
  // ALU and multiplier requests from ID
  input  ex_pkg::alu_req_t  alu_req_i,
  input  logic              alu_en_i,
  input  ex_pkg::mult_req_t mult_req_i,
  input  logic              mult_en_i,
  input  ex_pkg::word_t     alu_operand_c_i,
  // CSR and load/store side
  input  logic              csr_access_i,
  input  ex_pkg::word_t     csr_rdata_i,
  input  logic              lsu_en_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  // Pipeline control
  input  logic              wb_ready_i,
  input  logic              branch_in_ex_i,
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  // Register file ports
  output ex_pkg::rf_port_t  regfile_alu_fw_o,
  output ex_pkg::rf_port_t  regfile_wb_o,
  output logic              mult_multicycle_o,
  // To IF
  output logic              branch_decision_o,
  output ex_pkg::word_t     jump_target_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);
  import ex_pkg::*;

  word_t alu_result;
  logic  alu_cmp;
  word_t mult_result;
  logic  mult_ready;
  logic  ex_ready;

  // Branch condition and target go straight back to fetch
  assign branch_decision_o = alu_cmp;
  assign jump_target_o     = alu_operand_c_i;

  ex_alu i_ex_alu (
    .req_i    (alu_req_i),
    .result_o (alu_result),
    .cmp_o    (alu_cmp)
  );

  // Multiplier leaves DONE only when the stage accepts
  ex_mult i_ex_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .en_i         (mult_en_i),
    .req_i        (mult_req_i),
    .ex_ready_i   (ex_ready),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_writeback i_ex_writeback (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_en_i            (alu_en_i),
    .mult_en_i           (mult_en_i),
    .csr_access_i        (csr_access_i),
    .lsu_en_i            (lsu_en_i),
    .alu_result_i        (alu_result),
    .mult_result_i       (mult_result),
    .csr_rdata_i         (csr_rdata_i),
    .lsu_rdata_i         (lsu_rdata_i),
    .mult_ready_i        (mult_ready),
    .lsu_ready_ex_i      (lsu_ready_ex_i),
    .lsu_err_i           (lsu_err_i),
    .wb_ready_i          (wb_ready_i),
    .branch_in_ex_i      (branch_in_ex_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_we_i        (regfile_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .regfile_waddr_i     (regfile_waddr_i),
    .fw_port_o           (regfile_alu_fw_o),
    .wb_port_o           (regfile_wb_o),
    .ex_ready_o          (ex_ready),
    .ex_valid_o          (ex_valid_o)
  );

  assign ex_ready_o = ex_ready;

endmodule

/* src/ex_writeback.sv */
// Forwarding port mux, EX/WB register for the load/store port and stage ready and valid logic
`timescale 1ns/100ps

module ex_writeback (
  input  logic              clk,
  input  logic              rst_n,
  // Unit enables from ID
  input  logic              alu_en_i,
  input  logic              mult_en_i,
  input  logic              csr_access_i,
  input  logic              lsu_en_i,
  // Result sources
  input  ex_pkg::word_t     alu_result_i,
  input  ex_pkg::word_t     mult_result_i,
  input  ex_pkg::word_t     csr_rdata_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  // Stall sources
  input  logic              mult_ready_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  input  logic              wb_ready_i,
  input  logic              branch_in_ex_i,
  // Destination registers
  input  logic              regfile_alu_we_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  // Write ports and handshake levels
  output ex_pkg::rf_port_t  fw_port_o,
  output ex_pkg::rf_port_t  wb_port_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);
  import ex_pkg::*;

  word_t     fw_wdata;
  logic      lsu_we_d;
  logic      lsu_we_q;
  reg_addr_t lsu_waddr_q;
  logic      units_ready;
  logic      ex_valid;

  //////////////////////////////////////////////////
  // Forwarding port
  //////////////////////////////////////////////////

  // CSR wins over multiplier, multiplier over ALU
  always_comb begin
    fw_wdata = '0;
    if (csr_access_i) begin
      fw_wdata = csr_rdata_i;
    end else if (mult_en_i) begin
      fw_wdata = mult_result_i;
    end else if (alu_en_i) begin
      fw_wdata = alu_result_i;
    end
  end

  assign fw_port_o = '{we: regfile_alu_we_i, waddr: regfile_alu_waddr_i, wdata: fw_wdata};

  //////////////////////////////////////////////////
  // EX/WB register for the load/store port
  //////////////////////////////////////////////////

  // A faulting access never writes the register file
  assign lsu_we_d = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q    <= 1'b0;
      lsu_waddr_q <= '0;
    end else if (ex_valid) begin
      lsu_we_q <= lsu_we_d;
      // Address only moves for a real write
      if (lsu_we_d) begin
        lsu_waddr_q <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // WB takes a bubble, flush the old strobe
      lsu_we_q <= 1'b0;
    end
  end

  // Load data arrives straight from memory
  assign wb_port_o = '{we: lsu_we_q, waddr: lsu_waddr_q, wdata: lsu_rdata_i};

  //////////////////////////////////////////////////
  // Ready and valid
  //////////////////////////////////////////////////

  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // Branches finish in EX and never wait for WB
  assign ex_ready_o = units_ready | branch_in_ex_i;

  // Valid looks only forward, so it does not depend on ex_ready
  assign ex_valid   = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;
  assign ex_valid_o = ex_valid;

endmodule
